// ==== dv/usb_rx_sva.sv ====
/*
 * USB receive top-level assertions
 * Packet framing and bus event rules, bound to usb_rx_top
 */
`timescale 1ns/1ps

module usb_rx_sva (
    input logic clk,
    input logic rst_n,
    input logic packet_valid,
    input logic packet_sop,
    input logic reset_detect,
    input logic suspend_detect,
    input logic resume_detect
);

    int fail_cnt = 0;   // Read by the testbench

    // Start mark only on a valid byte
    a_sop_valid: assert property (@(posedge clk) disable iff (!rst_n)
        packet_sop |-> packet_valid)
        else begin
            fail_cnt++;
            $error("packet_sop high without packet_valid");
        end

    a_resume_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resume_detect |=> !resume_detect)
        else begin
            fail_cnt++;
            $error("resume_detect held longer than one cycle");
        end

    // Bus events quiet in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !reset_detect && !suspend_detect && !resume_detect)
        else begin
            fail_cnt++;
            $error("bus event output high during reset");
        end

endmodule

bind usb_rx_top usb_rx_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .packet_valid   (packet_valid),
    .packet_sop     (packet_sop),
    .reset_detect   (reset_detect),
    .suspend_detect (suspend_detect),
    .resume_detect  (resume_detect)
);

// ==== dv/usb_rx_tb.sv ====
/*
 * USB receive protocol handler testbench
 * Directed token, data, handshake and error packets, plus bus reset,
 * suspend and resume on the line state
 */
`timescale 1ns/1ps
`include "usb_consts.svh"

module usb_rx_tb import usb_pid_pkg::*, usb_line_pkg::*;;

    localparam int reset_cyc   = 20;
    localparam int suspend_cyc = 60;
    localparam int max_cycles  = 3000;
    localparam int eop_wait    = 50;

    logic        clk;
    logic        rst_n;
    rx_byte_t    rx_data;
    logic        rx_valid;
    logic        rx_active;
    logic        rx_error;
    line_state_t line_state;
    rx_byte_t    packet_data;
    logic        packet_valid;
    logic        packet_sop;
    logic        packet_eop;
    pid_t        pid;
    dev_addr_t   dev_addr;
    endp_t       endp;
    logic        crc_valid;
    logic        reset_detect;
    logic        suspend_detect;
    logic        resume_detect;

    int          n_checks = 0;
    int          n_errors = 0;
    int          n_other  = 0;
    int          cycles   = 0;
    logic [15:0] lfsr;
    rx_byte_t    tx_q[$];     // Packet being sent
    rx_byte_t    got_q[$];    // Bytes seen on packet_data
    logic        sop_q[$];
    int          eop_cnt  = 0;
    logic        eop_crc  = 1'b0;   // crc_valid seen with the last eop

    usb_rx_top #(
        .reset_cycles   (reset_cyc),
        .suspend_cycles (suspend_cyc)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_active      (rx_active),
        .rx_error       (rx_error),
        .line_state     (line_state),
        .packet_data    (packet_data),
        .packet_valid   (packet_valid),
        .packet_sop     (packet_sop),
        .packet_eop     (packet_eop),
        .pid            (pid),
        .dev_addr       (dev_addr),
        .endp           (endp),
        .crc_valid      (crc_valid),
        .reset_detect   (reset_detect),
        .suspend_detect (suspend_detect),
        .resume_detect  (resume_detect)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Random bits and reference CRCs
    ////////////////////////////////////////////////////////////
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 16'hB400;   // x^16 + x^14 + x^13 + x^11 + 1
        return b;
    endfunction

    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[14:0], lfsr_bit()};
        return v;
    endfunction

    // Address then endpoint, LSB first
    function automatic crc5_t ref_crc5(dev_addr_t addr, endp_t ep);
        logic [10:0] bits;
        crc5_t       c;
        bits = {ep, addr};
        c    = `USB_CRC5_INIT;
        for (int i = 0; i < 11; i++) begin
            if (c[0] ^ bits[i])
                c = (c >> 1) ^ `USB_CRC5_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    function automatic crc16_t ref_crc16(int first);
        crc16_t c;
        c = `USB_CRC16_INIT;
        for (int k = first; k < tx_q.size(); k++) begin
            for (int i = 0; i < 8; i++) begin
                if (c[0] ^ tx_q[k][i])
                    c = (c >> 1) ^ `USB_CRC16_POLY;
                else
                    c = c >> 1;
            end
        end
        return c;
    endfunction

    function automatic rx_byte_t pid_byte(pid_t p);
        return {~p, p};   // Check nibble on top
    endfunction

    ////////////////////////////////////////////////////////////
    // Output monitor and run limit
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n) begin
            if (packet_valid) begin
                got_q.push_back(packet_data);
                sop_q.push_back(packet_sop);
            end
            if (packet_eop) begin
                eop_cnt++;
                eop_crc = crc_valid;
            end
        end
    end

    task automatic print_counts();
        $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion errors: %0d",
                 n_checks, n_errors, n_other, dut0.u_sva.fail_cnt);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            print_counts();
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Drive and check helpers
    ////////////////////////////////////////////////////////////
    task automatic check_val(string what, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        assert (got == exp) else begin
            n_errors++;
            $display("Fail at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // err_at >= 0 raises rx_error in place of that byte
    task automatic send_packet(int err_at);
        int n;
        n = (err_at >= 0) ? err_at : tx_q.size();
        got_q.delete();
        sop_q.delete();
        @(negedge clk);
        rx_active = 1'b1;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            rx_valid = 1'b1;
            rx_data  = tx_q[i];
        end
        if (err_at >= 0) begin
            @(negedge clk);
            rx_valid = 1'b0;
            rx_error = 1'b1;
        end
        @(negedge clk);
        rx_valid  = 1'b0;
        rx_error  = 1'b0;
        rx_active = 1'b0;
        rx_data   = '0;
    endtask

    // Waits for one eop, then checks the forwarded bytes
    task automatic finish_packet(int start);
        int t;
        t = 0;
        while (eop_cnt == start && t < eop_wait) begin
            @(negedge clk);
            t++;
        end
        if (eop_cnt == start) begin
            n_other++;
            $display("No end of packet seen within %0d cycles", eop_wait);
        end
        repeat (2) @(negedge clk);
        check_val("eop count", eop_cnt - start, 1);
        check_val("byte count", got_q.size(), tx_q.size());
        for (int i = 0; i < got_q.size() && i < tx_q.size(); i++) begin
            check_val("packet_data", got_q[i], tx_q[i]);
            check_val("packet_sop", sop_q[i], i == 0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic run_token(pid_t p, crc5_t flip);
        dev_addr_t addr;
        endp_t     ep;
        crc5_t     field;
        int        start;
        addr  = dev_addr_t'(rand_bits(7));
        ep    = endp_t'(rand_bits(4));
        field = ~ref_crc5(addr, ep) ^ flip;
        tx_q.delete();
        tx_q.push_back(pid_byte(p));
        tx_q.push_back({ep[0], addr});
        tx_q.push_back({field, ep[3:1]});
        start = eop_cnt;
        send_packet(-1);
        finish_packet(start);
        check_val("pid", pid, p);
        check_val("dev_addr", dev_addr, addr);
        check_val("endp", endp, ep);
        check_val("token crc_valid", crc_valid, field == ~ref_crc5(addr, ep));
    endtask

    task automatic run_data(pid_t p, logic corrupt);
        int     len;
        int     idx;
        int     start;
        crc16_t crc;
        logic   good;
        len = 1 + rand_bits(3);
        tx_q.delete();
        tx_q.push_back(pid_byte(p));
        for (int i = 0; i < len; i++)
            tx_q.push_back(rx_byte_t'(rand_bits(8)));
        crc = ~ref_crc16(1);
        tx_q.push_back(crc[7:0]);          // Low byte first
        tx_q.push_back(crc[15:8]);
        if (corrupt) begin
            idx       = 1 + rand_bits(3) % len;
            tx_q[idx] = tx_q[idx] ^ (8'h01 << rand_bits(3));
        end
        good  = !corrupt;                  // Single bit errors always caught
        start = eop_cnt;
        send_packet(-1);
        finish_packet(start);
        check_val("pid", pid, p);
        check_val("crc_valid at eop", eop_crc, good);
        check_val("data crc_valid", crc_valid, good);
    endtask

    // exp_crc is the verdict of the packet before
    task automatic test_pid_only(logic exp_crc);
        int start;
        tx_q.delete();
        tx_q.push_back(pid_byte(pid_ack));
        start = eop_cnt;
        send_packet(-1);
        finish_packet(start);
        check_val("pid", pid, pid_ack);
        check_val("crc_valid after handshake", crc_valid, exp_crc);
    endtask

    task automatic test_rx_error();
        int start;
        run_data(pid_data1, 1'b0);
        tx_q.delete();
        tx_q.push_back(pid_byte(pid_data0));
        for (int i = 0; i < 4; i++)
            tx_q.push_back(rx_byte_t'(rand_bits(8)));
        start = eop_cnt;
        send_packet(3);                    // Error after PID and two bytes
        check_val("crc_valid after rx_error", crc_valid, 0);
        repeat (4) @(negedge clk);
        check_val("eop count after rx_error", eop_cnt - start, 0);
        check_val("crc_valid after rx_error", crc_valid, 0);
        run_data(pid_data0, 1'b0);          // Decoder recovered
    endtask

    task automatic test_bus_reset();
        @(negedge clk);
        line_state = ls_se0;
        for (int k = 1; k <= 30; k++) begin
            @(negedge clk);
            check_val("reset_detect in SE0", reset_detect, k > reset_cyc);
        end
        line_state = ls_j;
        @(negedge clk);
        check_val("reset_detect after SE0", reset_detect, 0);
        line_state = ls_se0;               // Too short for a reset
        for (int k = 1; k <= 10; k++) begin
            @(negedge clk);
            check_val("reset_detect in short SE0", reset_detect, 0);
        end
        line_state = ls_j;
        @(negedge clk);
        check_val("reset_detect after short SE0", reset_detect, 0);
    endtask

    task automatic test_suspend_resume();
        @(negedge clk);
        line_state = ls_se0;               // Restart the J count
        @(negedge clk);
        line_state = ls_j;
        for (int k = 1; k <= 70; k++) begin
            @(negedge clk);
            check_val("suspend_detect in J", suspend_detect, k > suspend_cyc);
        end
        line_state = ls_k;
        @(negedge clk);
        check_val("resume_detect on K", resume_detect, 1);
        check_val("suspend_detect on K", suspend_detect, 0);
        line_state = ls_j;
        @(negedge clk);
        check_val("resume_detect after K", resume_detect, 0);
        check_val("suspend_detect after K", suspend_detect, 0);
    endtask

    initial begin
        rst_n      = 1'b0;
        rx_data    = '0;
        rx_valid   = 1'b0;
        rx_active  = 1'b0;
        rx_error   = 1'b0;
        line_state = ls_j;
        lfsr       = 16'd60738;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_val("packet_valid after reset", packet_valid, 0);
        check_val("packet_eop after reset", packet_eop, 0);
        check_val("crc_valid after reset", crc_valid, 0);

        run_token(pid_in, 5'd0);
        run_token(pid_out, 5'd0);
        run_token(pid_setup, 5'd0);
        test_pid_only(1'b1);               // Follows a good SETUP
        run_token(pid_out, 5'd1 << (rand_bits(3) % 5));
        for (int i = 0; i < 4; i++)
            run_data(i[0] ? pid_data1 : pid_data0, 1'b0);
        run_data(pid_data0, 1'b1);
        test_rx_error();
        test_bus_reset();
        test_suspend_resume();

        repeat (2) @(negedge clk);
        print_counts();
        if (n_errors == 0 && n_other == 0 && dut0.u_sva.fail_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
hw/usb_pid_pkg.sv
hw/usb_line_pkg.sv
hw/usb_crc_check.sv
hw/usb_rx_decoder.sv
hw/usb_line_monitor.sv
hw/usb_rx_top.sv
dv/usb_rx_sva.sv
dv/usb_rx_tb.sv

// ==== hw/usb_crc_check.sv ====
/*
 * USB receive CRC checker
 * Running CRC5 over token fields and CRC16 over data packets,
 * with a token verdict and a data residue verdict
 */
`timescale 1ns/1ps
`include "usb_consts.svh"

module usb_crc_check import usb_pid_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  rx_byte_t crc_byte,
    input  logic     crc5_start,   // First token byte
    input  logic     crc5_last,    // Second token byte
    input  logic     crc16_start,  // First data byte
    input  logic     crc16_step,   // Later data bytes
    output logic     token_crc_ok,
    output logic     data_crc_ok
);

    crc5_t  crc5_q;
    crc5_t  crc5_tail;   // CRC5 after the endpoint bits of the last byte
    crc16_t crc16_q;
    crc16_t crc16_d;

    // LSB first, only the low nbits of data are shifted in
    function automatic crc5_t crc5_update(crc5_t crc, rx_byte_t data, int unsigned nbits);
        crc5_t c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (i < nbits) begin
                if (c[0] ^ data[i])
                    c = (c >> 1) ^ `USB_CRC5_POLY;
                else
                    c = c >> 1;
            end
        end
        return c;
    endfunction

    function automatic crc16_t crc16_update(crc16_t crc, rx_byte_t data);
        crc16_t c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ `USB_CRC16_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // Token check
    ////////////////////////////////////////////////////////////
    assign crc5_tail    = crc5_update(crc5_q, crc_byte, 3);
    assign token_crc_ok = crc5_last && (crc_byte[7:3] == ~crc5_tail); // Field is inverted

    ////////////////////////////////////////////////////////////
    // Data check
    ////////////////////////////////////////////////////////////
    assign crc16_d = crc16_update(crc16_start ? `USB_CRC16_INIT : crc16_q, crc_byte);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc5_q      <= `USB_CRC5_INIT;
            crc16_q     <= `USB_CRC16_INIT;
            data_crc_ok <= 1'b0;
        end else begin
            if (crc5_start)
                crc5_q <= crc5_update(`USB_CRC5_INIT, crc_byte, 8); // Addr and endp[0]
            if (crc16_start || crc16_step) begin
                crc16_q     <= crc16_d;
                data_crc_ok <= (crc16_d == `USB_CRC16_RESIDUE);
            end
        end
    end

endmodule

// ==== hw/usb_line_monitor.sv ====
/*
 * USB line-state monitor
 * Bus reset from long SE0, suspend from long idle J,
 * and a resume pulse on K while suspended
 */
`timescale 1ns/1ps
`include "usb_consts.svh"

module usb_line_monitor import usb_line_pkg::*; #(
    parameter int reset_cycles   = `USB_RESET_CYCLES_DEF,
    parameter int suspend_cycles = `USB_SUSPEND_CYCLES_DEF
) (
    input  logic        clk,
    input  logic        rst_n,
    input  line_state_t line_state,
    output logic        reset_detect,
    output logic        suspend_detect,
    output logic        resume_detect
);

    localparam dur_cnt_t reset_lim   = dur_cnt_t'(reset_cycles);
    localparam dur_cnt_t suspend_lim = dur_cnt_t'(suspend_cycles);

    dur_cnt_t se0_cnt;  // Consecutive SE0 samples
    dur_cnt_t j_cnt;    // Consecutive J samples

    function automatic dur_cnt_t sat_inc(dur_cnt_t cnt);
        return (&cnt) ? cnt : cnt + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            se0_cnt        <= '0;
            j_cnt          <= '0;
            reset_detect   <= 1'b0;
            suspend_detect <= 1'b0;
            resume_detect  <= 1'b0;
        end else begin
            resume_detect <= 1'b0;

            ////////////////////////////////////////////////////////////
            // Bus reset
            ////////////////////////////////////////////////////////////
            if (line_state == ls_se0) begin
                se0_cnt <= sat_inc(se0_cnt);
                if (se0_cnt >= reset_lim) begin
                    reset_detect   <= 1'b1;
                    suspend_detect <= 1'b0;   // Reset also wakes the device
                end
            end else begin
                se0_cnt      <= '0;
                reset_detect <= 1'b0;
            end

            ////////////////////////////////////////////////////////////
            // Suspend and resume
            ////////////////////////////////////////////////////////////
            if (line_state == ls_j) begin
                j_cnt <= sat_inc(j_cnt);
                if (j_cnt >= suspend_lim)
                    suspend_detect <= 1'b1;
            end else begin
                j_cnt <= '0;
            end

            if (suspend_detect && line_state == ls_k) begin
                resume_detect  <= 1'b1;     // One cycle, suspend gone next
                suspend_detect <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/usb_line_pkg.sv ====
/*
 * USB bus line-state types
 * UTMI line state encoding and the duration counter width
 */
package usb_line_pkg;

    // UTMI LineState[1:0]
    typedef enum logic [1:0] {
        ls_se0 = 2'd0,
        ls_j   = 2'd1,
        ls_k   = 2'd2,
        ls_se1 = 2'd3
    } line_state_t;

    // Long enough for 3 ms at 60 MHz
    typedef logic [23:0] dur_cnt_t;

endpackage

// ==== hw/usb_pid_pkg.sv ====
/*
 * USB packet protocol types
 * PID codes, receive FSM states and packet field widths
 */
package usb_pid_pkg;

    // PID codes as carried in the low nibble of the first byte
    typedef enum logic [3:0] {
        pid_rsvd  = 4'b0000,
        pid_out   = 4'b0001,
        pid_ack   = 4'b0010,
        pid_data0 = 4'b0011,
        pid_ping  = 4'b0100,
        pid_sof   = 4'b0101,
        pid_nyet  = 4'b0110,
        pid_data2 = 4'b0111,
        pid_split = 4'b1000,
        pid_in    = 4'b1001,
        pid_nak   = 4'b1010,
        pid_data1 = 4'b1011,
        pid_pre   = 4'b1100,
        pid_setup = 4'b1101,
        pid_stall = 4'b1110,
        pid_mdata = 4'b1111
    } pid_t;

    typedef enum logic [2:0] {
        st_idle,      // Waiting for a packet
        st_pid,       // PID seen, next byte decides the packet type
        st_token,     // Second token byte expected
        st_data,      // Payload and CRC16 bytes
        st_wait_eop   // Rest of packet forwarded unchecked
    } rx_state_t;

    typedef logic [7:0]  rx_byte_t;
    typedef logic [6:0]  dev_addr_t;
    typedef logic [3:0]  endp_t;
    typedef logic [4:0]  crc5_t;
    typedef logic [15:0] crc16_t;

endpackage

// ==== hw/usb_rx_decoder.sv ====
/*
 * USB receive packet decoder
 * Marks packet boundaries on the UTMI byte stream, extracts PID and
 * token fields, and steers the CRC checker
 */
`timescale 1ns/1ps

module usb_rx_decoder import usb_pid_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  rx_byte_t  rx_data,
    input  logic      rx_valid,
    input  logic      rx_active,
    input  logic      rx_error,
    input  logic      token_crc_ok,
    input  logic      data_crc_ok,
    output rx_byte_t  packet_data,
    output logic      packet_valid,
    output logic      packet_sop,
    output logic      packet_eop,
    output pid_t      pid,
    output dev_addr_t dev_addr,
    output endp_t     endp,
    output logic      crc_valid,
    output rx_byte_t  crc_byte,
    output logic      crc5_start,
    output logic      crc5_last,
    output logic      crc16_start,
    output logic      crc16_step
);

    rx_state_t state;
    logic      rx_drop;    // Discarding the tail of an errored packet
    logic      take;       // Byte accepted this cycle
    logic      pid_token;
    logic      pid_data;

    function automatic logic is_token(pid_t p);
        return p inside {pid_out, pid_in, pid_setup, pid_ping, pid_sof};
    endfunction

    function automatic logic is_data(pid_t p);
        return p inside {pid_data0, pid_data1, pid_data2, pid_mdata};
    endfunction

    assign take      = rx_active && rx_valid && !rx_error && !rx_drop;
    assign pid_token = is_token(pid);
    assign pid_data  = is_data(pid);

    ////////////////////////////////////////////////////////////
    // CRC checker steering
    ////////////////////////////////////////////////////////////
    assign crc_byte    = rx_data;
    assign crc5_start  = take && (state == st_pid) && pid_token;
    assign crc5_last   = take && (state == st_token);
    assign crc16_start = take && (state == st_pid) && pid_data;
    assign crc16_step  = take && (state == st_data);

    // Payload register
    always_ff @(posedge clk) begin
        if (take)
            packet_data <= rx_data;
    end

    ////////////////////////////////////////////////////////////
    // Receive FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            rx_drop      <= 1'b0;
            packet_valid <= 1'b0;
            packet_sop   <= 1'b0;
            packet_eop   <= 1'b0;
            pid          <= pid_rsvd;
            dev_addr     <= '0;
            endp         <= '0;
            crc_valid    <= 1'b0;
        end else begin
            packet_valid <= take;
            packet_sop   <= take && (state == st_idle);
            packet_eop   <= 1'b0;
            rx_drop      <= rx_active && (rx_error || rx_drop); // Held until rx_active drops

            if (rx_error) begin
                state     <= st_idle;
                crc_valid <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        if (take) begin
                            pid   <= pid_t'(rx_data[3:0]); // Check nibble ignored
                            state <= st_pid;
                        end
                    end
                    st_pid: begin
                        if (!rx_active) begin
                            state      <= st_idle;     // PID-only packet
                            packet_eop <= 1'b1;
                        end else if (take) begin
                            if (pid_token) begin
                                dev_addr <= rx_data[6:0];
                                endp[0]  <= rx_data[7];
                                state    <= st_token;
                            end else if (pid_data) begin
                                state <= st_data;
                            end else begin
                                state <= st_wait_eop;
                            end
                        end
                    end
                    st_token: begin
                        if (!rx_active) begin
                            state      <= st_idle;     // Short token, verdict kept
                            packet_eop <= 1'b1;
                        end else if (take) begin
                            endp[3:1] <= rx_data[2:0];
                            crc_valid <= token_crc_ok;
                            state     <= st_wait_eop;
                        end
                    end
                    st_data: begin
                        if (!rx_active) begin
                            state      <= st_idle;
                            packet_eop <= 1'b1;
                            crc_valid  <= data_crc_ok;
                        end
                    end
                    st_wait_eop: begin
                        if (!rx_active) begin
                            state      <= st_idle;
                            packet_eop <= 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

// ==== hw/usb_rx_top.sv ====
/*
 * USB receive protocol handler
 * Packet decoder, CRC checker and line-state monitor behind a UTMI PHY
 */
`timescale 1ns/1ps
`include "usb_consts.svh"

module usb_rx_top import usb_pid_pkg::*, usb_line_pkg::*; #(
    parameter int reset_cycles   = `USB_RESET_CYCLES_DEF,
    parameter int suspend_cycles = `USB_SUSPEND_CYCLES_DEF
) (
    input  logic        clk,
    input  logic        rst_n,
    // UTMI receive
    input  rx_byte_t    rx_data,
    input  logic        rx_valid,
    input  logic        rx_active,
    input  logic        rx_error,
    input  line_state_t line_state,
    // Decoded packet stream
    output rx_byte_t    packet_data,
    output logic        packet_valid,
    output logic        packet_sop,
    output logic        packet_eop,
    output pid_t        pid,
    output dev_addr_t   dev_addr,
    output endp_t       endp,
    output logic        crc_valid,
    // Bus events
    output logic        reset_detect,
    output logic        suspend_detect,
    output logic        resume_detect
);

    // Decoder to CRC checker
    rx_byte_t crc_byte;
    logic     crc5_start;
    logic     crc5_last;
    logic     crc16_start;
    logic     crc16_step;
    logic     token_crc_ok;
    logic     data_crc_ok;

    usb_rx_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_active    (rx_active),
        .rx_error     (rx_error),
        .token_crc_ok (token_crc_ok),
        .data_crc_ok  (data_crc_ok),
        .packet_data  (packet_data),
        .packet_valid (packet_valid),
        .packet_sop   (packet_sop),
        .packet_eop   (packet_eop),
        .pid          (pid),
        .dev_addr     (dev_addr),
        .endp         (endp),
        .crc_valid    (crc_valid),
        .crc_byte     (crc_byte),
        .crc5_start   (crc5_start),
        .crc5_last    (crc5_last),
        .crc16_start  (crc16_start),
        .crc16_step   (crc16_step)
    );

    usb_crc_check u_crc (
        .clk          (clk),
        .rst_n        (rst_n),
        .crc_byte     (crc_byte),
        .crc5_start   (crc5_start),
        .crc5_last    (crc5_last),
        .crc16_start  (crc16_start),
        .crc16_step   (crc16_step),
        .token_crc_ok (token_crc_ok),
        .data_crc_ok  (data_crc_ok)
    );

    usb_line_monitor #(
        .reset_cycles   (reset_cycles),
        .suspend_cycles (suspend_cycles)
    ) u_line (
        .clk            (clk),
        .rst_n          (rst_n),
        .line_state     (line_state),
        .reset_detect   (reset_detect),
        .suspend_detect (suspend_detect),
        .resume_detect  (resume_detect)
    );

endmodule

// ==== include/usb_consts.svh ====
/*
 * USB receive constants
 * CRC seeds, polynomials and residue, plus default line-state
 * detection times for a 60 MHz UTMI clock
 */
`ifndef USB_CONSTS_SVH
`define USB_CONSTS_SVH

// Token CRC, x^5 + x^2 + 1 in reflected form
`define USB_CRC5_INIT          5'h1F
`define USB_CRC5_POLY          5'h14

// Data CRC, x^16 + x^15 + x^2 + 1 in reflected form
`define USB_CRC16_INIT         16'hFFFF
`define USB_CRC16_POLY         16'hA001
`define USB_CRC16_RESIDUE      16'hB001  // Good packet incl. both CRC bytes

// Detection times in clock cycles
`define USB_RESET_CYCLES_DEF   150       // 2.5 us SE0
`define USB_SUSPEND_CYCLES_DEF 180000    // 3 ms idle J

`endif
